/* hdl/llc_mem_pkg.sv */
// llc local memory package
// cache geometry, field types and the packed metadata layout
package llc_mem_pkg;

    // geometry
    localparam int llc_ways           = 4;
    localparam int llc_sets           = 32;
    localparam int llc_set_bits       = 5;
    localparam int llc_banks          = 2;
    localparam int llc_bank_words     = 16;
    localparam int llc_bank_addr_bits = 4;

    // field widths
    localparam int llc_tag_bits   = 10;
    localparam int llc_owner_bits = 2;
    localparam int llc_state_bits = 3;
    localparam int llc_line_bits  = 64;
    localparam int llc_meta_bits  = 17;

    // metadata word layout, tag in the low bits
    localparam int meta_tag_lo    = 0;
    localparam int meta_tag_hi    = 9;
    localparam int meta_owner_lo  = 10;
    localparam int meta_owner_hi  = 11;
    localparam int meta_state_lo  = 12;
    localparam int meta_state_hi  = 14;
    localparam int meta_dirty_pos = 15;
    localparam int meta_hprot_pos = 16;

    typedef logic [llc_set_bits-1:0]       llc_set_t;
    typedef logic [$clog2(llc_ways)-1:0]   llc_way_t;
    typedef logic [llc_tag_bits-1:0]       llc_tag_t;
    typedef logic [llc_owner_bits-1:0]     llc_owner_t;
    typedef logic [llc_state_bits-1:0]     llc_state_t;
    typedef logic [llc_line_bits-1:0]      line_t;
    typedef logic [llc_meta_bits-1:0]      meta_word_t;

    // one bit per way
    typedef logic [llc_ways-1:0]           way_mask_t;

endpackage

/* hdl/llc_wr_encode.sv */
// llc write encoder
// packs metadata fields, builds the bit mask and decodes per-way, per-bank write enables
`timescale 1ns/100ps

module llc_wr_encode (
    input  logic                    wr_en_i,
    input  llc_mem_pkg::way_mask_t  wr_flush_i,
    input  llc_mem_pkg::llc_set_t   set_i,
    input  llc_mem_pkg::llc_way_t   way_i,
    input  llc_mem_pkg::llc_tag_t   wr_tag_i,
    input  llc_mem_pkg::llc_owner_t wr_owner_i,
    input  llc_mem_pkg::llc_state_t wr_state_i,
    input  logic                    wr_dirty_i,
    input  logic                    wr_hprot_i,
    input  llc_mem_pkg::line_t      wr_line_i,

    output llc_mem_pkg::meta_word_t wr_meta_o,
    output llc_mem_pkg::meta_word_t wr_meta_mask_o,
    output llc_mem_pkg::line_t      wr_line_o,
    output logic [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks-1:0] meta_we_o,
    output logic [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks-1:0] line_we_o
);
    import llc_mem_pkg::*;

    logic [llc_set_bits-llc_bank_addr_bits-1:0] bank_sel;
    logic                                       flush_any;
    logic                                       way_hit;
    logic                                       bank_hit;

    // bank is picked by the top bit of the set index
    assign bank_sel  = set_i[llc_set_bits-1:llc_bank_addr_bits];
    assign flush_any = |wr_flush_i;

    // line data goes to every line bank, only enables differ
    assign wr_line_o = wr_line_i;

    always_comb begin
        wr_meta_o = '0;
        wr_meta_o[meta_tag_hi:meta_tag_lo]     = wr_tag_i;
        wr_meta_o[meta_owner_hi:meta_owner_lo] = wr_owner_i;
        wr_meta_o[meta_state_hi:meta_state_lo] = wr_state_i;
        wr_meta_o[meta_dirty_pos]              = wr_dirty_i;
        wr_meta_o[meta_hprot_pos]              = wr_hprot_i;
    end

    // a flush only touches state and dirty, a normal write covers the whole word
    always_comb begin
        wr_meta_mask_o = '0;
        if (wr_en_i) begin
            wr_meta_mask_o = '1;
        end else if (flush_any) begin
            wr_meta_mask_o[meta_state_hi:meta_state_lo] = '1;
            wr_meta_mask_o[meta_dirty_pos]              = 1'b1;
        end
    end

    // enable index is way * banks + bank
    always_comb begin
        meta_we_o = '0;
        line_we_o = '0;
        way_hit   = 1'b0;
        bank_hit  = 1'b0;
        for (int w = 0; w < llc_ways; w++) begin
            way_hit = wr_en_i && (way_i == llc_way_t'(w));
            for (int b = 0; b < llc_banks; b++) begin
                bank_hit = (int'(bank_sel) == b);
                meta_we_o[w*llc_banks+b] = bank_hit && (wr_flush_i[w] || way_hit);
                line_we_o[w*llc_banks+b] = bank_hit && way_hit;
            end
        end
    end

endmodule

/* hdl/llc_sram.sv */
// behavioural single-port SRAM bank
// bit-masked write and registered read, payload type set by parameter
`timescale 1ns/100ps

module llc_sram #(
    parameter type payload_t = llc_mem_pkg::line_t
) (
    input  logic                                     clk,
    input  logic                                     re_i,
    input  logic                                     we_i,
    input  logic [llc_mem_pkg::llc_bank_addr_bits-1:0] addr_i,
    input  payload_t                                 wdata_i,
    input  payload_t                                 wmask_i,
    output payload_t                                 rdata_o
);
    import llc_mem_pkg::*;

    payload_t mem [llc_bank_words];

    // only masked bits change, the rest keep the stored value
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
        end
    end

    // read during write returns the old word
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* hdl/llc_rd_decode.sv */
// llc read decoder
// selects the bank that was read for each way and unpacks the metadata fields
`timescale 1ns/100ps

module llc_rd_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_en_i,
    input  llc_mem_pkg::llc_set_t   set_i,
    input  llc_mem_pkg::meta_word_t bank_meta_i [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks],
    input  llc_mem_pkg::line_t      bank_line_i [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks],

    output llc_mem_pkg::llc_tag_t   rd_tag_o   [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_owner_t rd_owner_o [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_state_t rd_state_o [llc_mem_pkg::llc_ways],
    output logic                    rd_dirty_o [llc_mem_pkg::llc_ways],
    output logic                    rd_hprot_o [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::line_t      rd_line_o  [llc_mem_pkg::llc_ways]
);
    import llc_mem_pkg::*;

    logic [llc_set_bits-llc_bank_addr_bits-1:0] rd_bank_q;
    meta_word_t                                 sel_meta [llc_ways];

    // bank index of the read in flight, held until the next read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_bank_q <= '0;
        end else if (rd_en_i) begin
            rd_bank_q <= set_i[llc_set_bits-1:llc_bank_addr_bits];
        end
    end

    always_comb begin
        for (int w = 0; w < llc_ways; w++) begin
            sel_meta[w]   = bank_meta_i[w*llc_banks+int'(rd_bank_q)];
            rd_line_o[w]  = bank_line_i[w*llc_banks+int'(rd_bank_q)];
            rd_tag_o[w]   = sel_meta[w][meta_tag_hi:meta_tag_lo];
            rd_owner_o[w] = sel_meta[w][meta_owner_hi:meta_owner_lo];
            rd_state_o[w] = sel_meta[w][meta_state_hi:meta_state_lo];
            rd_dirty_o[w] = sel_meta[w][meta_dirty_pos];
            rd_hprot_o[w] = sel_meta[w][meta_hprot_pos];
        end
    end

endmodule

/* hdl/llc_evict_table.sv */
// llc evict-way table
// one way pointer per set in flops, cleared on reset, read every cycle
`timescale 1ns/100ps

module llc_evict_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_evict_en_i,
    input  llc_mem_pkg::llc_set_t set_i,
    input  llc_mem_pkg::llc_way_t wr_evict_way_i,
    output llc_mem_pkg::llc_way_t rd_evict_way_o
);
    import llc_mem_pkg::*;

    llc_way_t evict_way_q [llc_sets];

    // a write shows up on the read one edge later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_sets; s++) begin
                evict_way_q[s] <= '0;
            end
            rd_evict_way_o <= '0;
        end else begin
            if (wr_evict_en_i) begin
                evict_way_q[set_i] <= wr_evict_way_i;
            end
            rd_evict_way_o <= evict_way_q[set_i];
        end
    end

endmodule

/* hdl/llc_localmem.sv */
// llc local memory top
// write encoder, metadata and line SRAM banks per way, read decoder and evict table
`timescale 1ns/100ps

module llc_localmem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_en_i,
    input  logic                    wr_en_i,
    input  llc_mem_pkg::way_mask_t  wr_flush_i,
    input  llc_mem_pkg::llc_set_t   set_i,
    input  llc_mem_pkg::llc_way_t   way_i,
    input  llc_mem_pkg::llc_tag_t   wr_tag_i,
    input  llc_mem_pkg::llc_owner_t wr_owner_i,
    input  llc_mem_pkg::llc_state_t wr_state_i,
    input  logic                    wr_dirty_i,
    input  logic                    wr_hprot_i,
    input  llc_mem_pkg::line_t      wr_line_i,
    input  logic                    wr_evict_en_i,
    input  llc_mem_pkg::llc_way_t   wr_evict_way_i,

    output llc_mem_pkg::llc_tag_t   rd_tag_o   [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_owner_t rd_owner_o [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_state_t rd_state_o [llc_mem_pkg::llc_ways],
    output logic                    rd_dirty_o [llc_mem_pkg::llc_ways],
    output logic                    rd_hprot_o [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::line_t      rd_line_o  [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_way_t   rd_evict_way_o
);
    import llc_mem_pkg::*;

    meta_word_t                         wr_meta;
    meta_word_t                         wr_meta_mask;
    line_t                              wr_line;
    logic [llc_ways*llc_banks-1:0]      meta_we;
    logic [llc_ways*llc_banks-1:0]      line_we;
    meta_word_t                         bank_meta [llc_ways*llc_banks];
    line_t                              bank_line [llc_ways*llc_banks];

    llc_wr_encode u_wr_encode (
        .wr_en_i        (wr_en_i),
        .wr_flush_i     (wr_flush_i),
        .set_i          (set_i),
        .way_i          (way_i),
        .wr_tag_i       (wr_tag_i),
        .wr_owner_i     (wr_owner_i),
        .wr_state_i     (wr_state_i),
        .wr_dirty_i     (wr_dirty_i),
        .wr_hprot_i     (wr_hprot_i),
        .wr_line_i      (wr_line_i),
        .wr_meta_o      (wr_meta),
        .wr_meta_mask_o (wr_meta_mask),
        .wr_line_o      (wr_line),
        .meta_we_o      (meta_we),
        .line_we_o      (line_we)
    );

    // banks share the low set bits as address, bank index is way * banks + bank
    for (genvar w = 0; w < llc_ways; w++) begin : g_way
        for (genvar b = 0; b < llc_banks; b++) begin : g_bank
            llc_sram #(.payload_t(meta_word_t)) u_meta_sram (
                .clk     (clk),
                .re_i    (rd_en_i),
                .we_i    (meta_we[w*llc_banks+b]),
                .addr_i  (set_i[llc_bank_addr_bits-1:0]),
                .wdata_i (wr_meta),
                .wmask_i (wr_meta_mask),
                .rdata_o (bank_meta[w*llc_banks+b])
            );

            // lines are always written whole
            llc_sram #(.payload_t(line_t)) u_line_sram (
                .clk     (clk),
                .re_i    (rd_en_i),
                .we_i    (line_we[w*llc_banks+b]),
                .addr_i  (set_i[llc_bank_addr_bits-1:0]),
                .wdata_i (wr_line),
                .wmask_i ('1),
                .rdata_o (bank_line[w*llc_banks+b])
            );
        end
    end

    llc_rd_decode u_rd_decode (
        .clk         (clk),
        .rst         (rst),
        .rd_en_i     (rd_en_i),
        .set_i       (set_i),
        .bank_meta_i (bank_meta),
        .bank_line_i (bank_line),
        .rd_tag_o    (rd_tag_o),
        .rd_owner_o  (rd_owner_o),
        .rd_state_o  (rd_state_o),
        .rd_dirty_o  (rd_dirty_o),
        .rd_hprot_o  (rd_hprot_o),
        .rd_line_o   (rd_line_o)
    );

    llc_evict_table u_evict_table (
        .clk            (clk),
        .rst            (rst),
        .wr_evict_en_i  (wr_evict_en_i),
        .set_i          (set_i),
        .wr_evict_way_i (wr_evict_way_i),
        .rd_evict_way_o (rd_evict_way_o)
    );

endmodule

/* verif/llc_localmem_sva.sv */
// write encoder assertions
// bound into the llc local memory top, checks enables and mask of the encoder
`timescale 1ns/100ps

module llc_localmem_sva (
    input logic                                                    clk,
    input logic                                                    rst,
    input logic                                                    wr_en_i,
    input logic [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks-1:0] meta_we_i,
    input logic [llc_mem_pkg::llc_ways*llc_mem_pkg::llc_banks-1:0] line_we_i,
    input llc_mem_pkg::meta_word_t                                 meta_mask_i
);
    import llc_mem_pkg::*;

    // a way never writes both of its banks
    for (genvar w = 0; w < llc_ways; w++) begin : g_way
        a_meta_we_one_bank: assert property (@(posedge clk) disable iff (!rst)
            $onehot0(meta_we_i[w*llc_banks +: llc_banks]))
            else $error("way %0d writes more than one metadata bank", w);
    end

    a_line_we_idle: assert property (@(posedge clk) disable iff (!rst)
        !wr_en_i |-> (line_we_i == '0))
        else $error("line bank written without a write strobe");

    a_full_mask: assert property (@(posedge clk) disable iff (!rst)
        wr_en_i |-> (meta_mask_i == '1))
        else $error("metadata mask not full on a normal write");

endmodule

// the encoder has no clock of its own, so the checker sits in the top
bind llc_localmem llc_localmem_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (u_wr_encode.wr_en_i),
    .meta_we_i   (u_wr_encode.meta_we_o),
    .line_we_i   (u_wr_encode.line_we_o),
    .meta_mask_i (u_wr_encode.wr_meta_mask_o)
);

/* verif/llc_localmem_tb.sv */
// llc local memory testbench
// directed tests against a reference model of metadata, lines and evict pointers
`timescale 1ns/100ps

module llc_localmem_tb;
    import llc_mem_pkg::*;

    localparam int          clk_period     = 8;
    localparam logic [31:0] lfsr_seed      = 32'h23f5;
    // tests take about 140 cycles
    localparam int          timeout_cycles = 2000;

    logic       clk;
    logic       rst;
    logic       rd_en_i;
    logic       wr_en_i;
    way_mask_t  wr_flush_i;
    llc_set_t   set_i;
    llc_way_t   way_i;
    llc_tag_t   wr_tag_i;
    llc_owner_t wr_owner_i;
    llc_state_t wr_state_i;
    logic       wr_dirty_i;
    logic       wr_hprot_i;
    line_t      wr_line_i;
    logic       wr_evict_en_i;
    llc_way_t   wr_evict_way_i;

    llc_tag_t   rd_tag   [llc_ways];
    llc_owner_t rd_owner [llc_ways];
    llc_state_t rd_state [llc_ways];
    logic       rd_dirty [llc_ways];
    logic       rd_hprot [llc_ways];
    line_t      rd_line  [llc_ways];
    llc_way_t   rd_evict_way;

    // valid marks the reference model entries that hold defined data
    llc_tag_t   ref_tag   [llc_sets][llc_ways];
    llc_owner_t ref_owner [llc_sets][llc_ways];
    llc_state_t ref_state [llc_sets][llc_ways];
    logic       ref_dirty [llc_sets][llc_ways];
    logic       ref_hprot [llc_sets][llc_ways];
    line_t      ref_line  [llc_sets][llc_ways];
    logic       ref_valid [llc_sets][llc_ways];
    llc_way_t   ref_evict [llc_sets];

    logic [31:0] lfsr_q;
    int          err_count;
    int          check_count;
    int          cycle_count;

    llc_localmem dut0 (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en_i),
        .wr_en_i        (wr_en_i),
        .wr_flush_i     (wr_flush_i),
        .set_i          (set_i),
        .way_i          (way_i),
        .wr_tag_i       (wr_tag_i),
        .wr_owner_i     (wr_owner_i),
        .wr_state_i     (wr_state_i),
        .wr_dirty_i     (wr_dirty_i),
        .wr_hprot_i     (wr_hprot_i),
        .wr_line_i      (wr_line_i),
        .wr_evict_en_i  (wr_evict_en_i),
        .wr_evict_way_i (wr_evict_way_i),
        .rd_tag_o       (rd_tag),
        .rd_owner_o     (rd_owner),
        .rd_state_o     (rd_state),
        .rd_dirty_o     (rd_dirty),
        .rd_hprot_o     (rd_hprot),
        .rd_line_o      (rd_line),
        .rd_evict_way_o (rd_evict_way)
    );

    always #(clk_period/2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = {val[62:0], lfsr_q[0]};
        end
        return val;
    endfunction

    task automatic check_field(input string test_name, input string field, input int way,
                               input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error %s: way %0d %s expected %h actual %h",
                     test_name, way, field, exp, act);
        end
    endtask

    // all tasks start and end on a falling edge
    task automatic write_way(input llc_set_t set, input llc_way_t way);
        set_i      = set;
        way_i      = way;
        wr_tag_i   = llc_tag_t'(next_bits(llc_tag_bits));
        wr_owner_i = llc_owner_t'(next_bits(llc_owner_bits));
        wr_state_i = llc_state_t'(next_bits(llc_state_bits));
        wr_dirty_i = next_bits(1);
        wr_hprot_i = next_bits(1);
        wr_line_i  = next_bits(llc_line_bits);
        wr_en_i    = 1'b1;
        ref_tag[set][way]   = wr_tag_i;
        ref_owner[set][way] = wr_owner_i;
        ref_state[set][way] = wr_state_i;
        ref_dirty[set][way] = wr_dirty_i;
        ref_hprot[set][way] = wr_hprot_i;
        ref_line[set][way]  = wr_line_i;
        ref_valid[set][way] = 1'b1;
        @(negedge clk);
        wr_en_i = 1'b0;
    endtask

    task automatic flush_ways(input llc_set_t set, input way_mask_t mask);
        set_i      = set;
        wr_flush_i = mask;
        wr_state_i = llc_state_t'(next_bits(llc_state_bits));
        wr_dirty_i = next_bits(1);
        for (int w = 0; w < llc_ways; w++) begin
            if (mask[w]) begin
                ref_state[set][w] = wr_state_i;
                ref_dirty[set][w] = wr_dirty_i;
            end
        end
        @(negedge clk);
        wr_flush_i = '0;
    endtask

    task automatic compare_ways(input llc_set_t set, input string test_name);
        for (int w = 0; w < llc_ways; w++) begin
            if (ref_valid[set][w]) begin
                check_field(test_name, "tag", w, ref_tag[set][w], rd_tag[w]);
                check_field(test_name, "owner", w, ref_owner[set][w], rd_owner[w]);
                check_field(test_name, "state", w, ref_state[set][w], rd_state[w]);
                check_field(test_name, "dirty", w, ref_dirty[set][w], rd_dirty[w]);
                check_field(test_name, "hprot", w, ref_hprot[set][w], rd_hprot[w]);
                check_field(test_name, "line", w, ref_line[set][w], rd_line[w]);
            end
        end
    endtask

    // read data must hold while set_i moves over to the other bank
    task automatic read_check(input llc_set_t set, input string test_name);
        set_i   = set;
        rd_en_i = 1'b1;
        @(negedge clk);
        rd_en_i = 1'b0;
        compare_ways(set, test_name);
        set_i = set ^ llc_set_t'(llc_bank_words);
        @(negedge clk);
        compare_ways(set, test_name);
    endtask

    task automatic write_evict(input llc_set_t set, input llc_way_t way);
        set_i          = set;
        wr_evict_way_i = way;
        wr_evict_en_i  = 1'b1;
        ref_evict[set] = way;
        @(negedge clk);
        wr_evict_en_i = 1'b0;
    endtask

    task automatic check_evict(input llc_set_t set, input string test_name);
        set_i = set;
        @(negedge clk);
        check_count++;
        if (rd_evict_way !== ref_evict[set]) begin
            err_count++;
            $display("error %s: set %0d evict way expected %0d actual %0d",
                     test_name, set, ref_evict[set], rd_evict_way);
        end
    endtask

    task automatic test_full_write();
        llc_set_t sets [4] = '{5'd3, 5'd10, 5'd21, 5'd30};
        foreach (sets[i]) begin
            for (int w = 0; w < llc_ways; w++) begin
                write_way(sets[i], llc_way_t'(w));
            end
        end
        foreach (sets[i]) begin
            read_check(sets[i], "full_write");
        end
    endtask

    task automatic test_way_isolation();
        for (int w = 0; w < llc_ways; w++) begin
            write_way(5'd18, llc_way_t'(w));
            read_check(5'd18, "way_isolation");
        end
    endtask

    // sets 12 and 28 share bank address 12
    task automatic test_bank_isolation();
        for (int w = 0; w < llc_ways; w++) begin
            write_way(5'd12, llc_way_t'(w));
            write_way(5'd28, llc_way_t'(w));
        end
        read_check(5'd12, "bank_isolation");
        read_check(5'd28, "bank_isolation");
    endtask

    task automatic test_flush();
        flush_ways(5'd3, 4'b0101);
        read_check(5'd3, "flush");
        flush_ways(5'd12, 4'b1010);
        read_check(5'd12, "flush");
        read_check(5'd28, "flush");
        flush_ways(5'd28, 4'b1111);
        read_check(5'd28, "flush");
        read_check(5'd12, "flush");
    endtask

    task automatic test_evict();
        llc_set_t sets [4] = '{5'd1, 5'd9, 5'd17, 5'd31};
        llc_way_t way;
        for (int s = 0; s < llc_sets; s++) begin
            check_evict(llc_set_t'(s), "evict_reset");
        end
        foreach (sets[i]) begin
            way = llc_way_t'(next_bits(2));
            if (way == '0) begin
                way = 2'd3;
            end
            write_evict(sets[i], way);
            check_evict(sets[i], "evict_write");
        end
        for (int s = 0; s < llc_sets; s++) begin
            check_evict(llc_set_t'(s), "evict_sweep");
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b0;
        rd_en_i        = 1'b0;
        wr_en_i        = 1'b0;
        wr_flush_i     = '0;
        set_i          = '0;
        way_i          = '0;
        wr_tag_i       = '0;
        wr_owner_i     = '0;
        wr_state_i     = '0;
        wr_dirty_i     = 1'b0;
        wr_hprot_i     = 1'b0;
        wr_line_i      = '0;
        wr_evict_en_i  = 1'b0;
        wr_evict_way_i = '0;
        lfsr_q         = lfsr_seed;
        err_count      = 0;
        check_count    = 0;
        cycle_count    = 0;
        for (int s = 0; s < llc_sets; s++) begin
            ref_evict[s] = '0;
            for (int w = 0; w < llc_ways; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        test_full_write();
        test_way_isolation();
        test_bank_isolation();
        test_flush();
        test_evict();

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/llc_mem_pkg.sv
hdl/llc_wr_encode.sv
hdl/llc_sram.sv
hdl/llc_rd_decode.sv
hdl/llc_evict_table.sv
hdl/llc_localmem.sv
verif/llc_localmem_sva.sv
verif/llc_localmem_tb.sv
